/* Bender.yml */
package:
  name: panel_control

sources:
  - design/panel_geom_pkg.sv
  - design/panel_cmd_pkg.sv
  - design/byte_capture.sv
  - design/cmd_dispatch.sv
  - design/pixel_writer.sv
  - design/panel_control.sv
  - target: test
    files:
      - bench/panel_control_assert.sv
      - bench/panel_control_tb.sv

/* bench/panel_control_assert.sv */
// assertions on the panel front end
// write range, sweep start after ready drops and write enable after reset
`timescale 1ns/1ns

module panel_control_assert import panel_geom_pkg::*; #(
    parameter int panel_rows = 4,
    parameter int panel_cols = 8
) (
    input logic       clk_in,
    input logic       reset,
    input logic       ready_for_data,
    input ram_write_t ram_write
);

    int assert_failures = 0;

    // every write lands inside the panel
    write_in_range: assert property (@(posedge clk_in) disable iff (reset)
        ram_write.we |-> (ram_write.addr.row < panel_rows) && (ram_write.addr.col < panel_cols)
            && (ram_write.addr.pixel < pixel_bytes)
    ) else begin
        assert_failures++;
        $error("RAM write outside the panel");
    end

    // busy phase always begins with a sweep write
    sweep_follows: assert property (@(posedge clk_in) disable iff (reset)
        $fell(ready_for_data) |=> ram_write.we
    ) else begin
        assert_failures++;
        $error("ready_for_data fell without a sweep write");
    end

    no_write_after_reset: assert property (@(posedge clk_in) reset |=> !ram_write.we)
    else begin
        assert_failures++;
        $error("RAM write enabled in the cycle after reset");
    end

endmodule

/* bench/panel_control_tb.sv */
// testbench for the LED panel command front end
// drives host bytes, mirrors RAM writes and checks them against a reference model
`timescale 1ns/1ns

module panel_control_tb import panel_geom_pkg::*, panel_cmd_pkg::*; ();

    localparam int panel_rows = 4;
    localparam int panel_cols = 8;
    localparam int rand_seed = 54707;
    localparam int chan_ops = 24;
    localparam int bright_ops = 24;
    localparam int unknown_ops = 6;
    localparam int pixel_ops = 4;
    localparam int pre_blank_ops = 3;
    localparam int pixel_cmd_bytes = 3 + pixel_bytes;
    localparam int total_bytes = chan_ops + bright_ops + 4 + unknown_ops
        + (pixel_ops + pre_blank_ops) * pixel_cmd_bytes + (1 + pixel_bytes) + 1;
    localparam int sweeps = 2;
    localparam int watchdog_cycles = total_bytes * 5 + sweeps * 100 + 200;
    localparam int m_idle = 0;
    localparam int m_bright = 1;
    localparam int m_fill = 2;
    localparam int m_pixel = 3;

    localparam logic [7:0] chan_list [6] = '{red_enable, red_disable, green_enable,
        green_disable, blue_enable, blue_disable};
    localparam logic [7:0] bright_list [8] = '{brightness_one, brightness_two,
        brightness_three, brightness_four, brightness_five, brightness_six,
        brightness_zero, brightness_nine};

    logic        clk_in;
    logic        reset;
    logic [7:0]  data_rx;
    logic        data_ready_n;
    logic        ready_for_data;
    logic [2:0]  rgb_enable;
    brightness_t brightness_enable;
    ram_write_t  ram_write;

    // observed RAM and expected state
    logic [7:0]  obs_ram [128];
    logic [7:0]  exp_ram [128];
    int          write_count;
    logic [2:0]  exp_rgb;
    brightness_t exp_bright;
    int          m_state;
    int          m_args;
    int          m_row;
    int          m_col;
    logic [7:0]  m_colour [pixel_bytes];
    int          errors;
    int          checks;
    int          tests;

    panel_control #(
        .panel_rows (panel_rows),
        .panel_cols (panel_cols)
    ) panel_control_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .ready_for_data    (ready_for_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_write         (ram_write)
    );

    bind panel_control panel_control_assert #(
        .panel_rows (panel_rows),
        .panel_cols (panel_cols)
    ) panel_control_assert_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .ready_for_data (ready_for_data),
        .ram_write      (ram_write)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    always @(posedge clk_in) begin
        if (ram_write.we === 1'b1) begin
            obs_ram[ram_write.addr] <= ram_write.data;
            write_count             <= write_count + 1;
        end
    end

    // row, col, pixel packed with pixel lowest
    function automatic int pixel_index(input int r, input int c, input int p);
        return (r * (2 ** col_w) + c) * 4 + p;
    endfunction

    function automatic void paint_panel(input logic use_fill);
        for (int r = 0; r < panel_rows; r++) begin
            for (int c = 0; c < panel_cols; c++) begin
                for (int p = 0; p < pixel_bytes; p++) begin
                    exp_ram[pixel_index(r, c, p)] = use_fill ? m_colour[p] : 8'h00;
                end
            end
        end
    endfunction

    function automatic bit is_opcode(input logic [7:0] b);
        opcode_t op;
        op = op.first();
        for (int i = 0; i < op.num(); i++) begin
            if (op == b) begin
                return 1'b1;
            end
            op = op.next();
        end
        return 1'b0;
    endfunction

    // expected panel state, advanced one host byte at a time
    function automatic void apply_reference(input logic [7:0] b);
        case (m_state)
            m_bright: begin
                exp_bright = b[brightness_levels-1:0];
                m_state    = m_idle;
            end
            m_fill: begin
                m_colour[m_args] = b;
                m_args++;
                if (m_args == pixel_bytes) begin
                    paint_panel(1'b1);
                    m_state = m_idle;
                end
            end
            m_pixel: begin
                if (m_args == 0) begin
                    m_row = int'(b[row_w-1:0]);
                end else if (m_args == 1) begin
                    m_col = int'(b[col_w-1:0]);
                end else begin
                    exp_ram[pixel_index(m_row, m_col, m_args - 2)] = b;
                end
                m_args++;
                if (m_args == 2 + pixel_bytes) begin
                    m_state = m_idle;
                end
            end
            default: begin
                m_args = 0;
                case (b)
                    red_enable:    exp_rgb[0] = 1'b1;
                    red_disable:   exp_rgb[0] = 1'b0;
                    green_enable:  exp_rgb[1] = 1'b1;
                    green_disable: exp_rgb[1] = 1'b0;
                    blue_enable:   exp_rgb[2] = 1'b1;
                    blue_disable:  exp_rgb[2] = 1'b0;
                    brightness_one, brightness_two, brightness_three,
                    brightness_four, brightness_five, brightness_six: begin
                        exp_bright[brightness_levels - int'(b - brightness_zero)] ^= 1'b1;
                    end
                    brightness_zero: exp_bright = '0;
                    brightness_nine: exp_bright = '1;
                    read_brightness: m_state = m_bright;
                    blank_panel:     paint_panel(1'b0);
                    fill_panel:      m_state = m_fill;
                    read_pixel:      m_state = m_pixel;
                    default: begin
                    end
                endcase
            end
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic check_state();
        check_value("ready_for_data", ready_for_data, 1'b1);
        check_value("rgb_enable", rgb_enable, exp_rgb);
        check_value("brightness_enable", brightness_enable, exp_bright);
        for (int a = 0; a < 128; a++) begin
            check_value($sformatf("ram[%0h]", a), obs_ram[a], exp_ram[a]);
        end
    endtask

    // called on a falling edge, returns on one
    task automatic send_byte(input logic [7:0] b);
        while (ready_for_data !== 1'b1) begin
            @(negedge clk_in);
        end
        data_rx      = b;
        data_ready_n = 1'b0;
        apply_reference(b);
        @(negedge clk_in);
        data_ready_n = 1'b1;
        repeat (3) @(negedge clk_in);
    endtask

    task automatic write_random_pixel();
        send_byte(read_pixel);
        repeat (2 + pixel_bytes) send_byte(8'($urandom));
    endtask

    task automatic wait_sweep();
        while (ready_for_data === 1'b1) begin
            @(negedge clk_in);
        end
        while (ready_for_data !== 1'b1) begin
            @(negedge clk_in);
        end
        repeat (2) @(negedge clk_in);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == errors_before ? "ok" : "mismatch");
    endtask

    initial begin
        logic [7:0] b;
        int         base_errors;
        int         base_writes;
        void'($urandom(rand_seed));
        reset        = 1'b1;
        data_rx      = 8'h00;
        data_ready_n = 1'b1;
        write_count  = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        exp_rgb      = 3'b111;
        exp_bright   = '1;
        m_state      = m_idle;
        for (int a = 0; a < 128; a++) begin
            obs_ram[a] = 8'(a * 37) ^ 8'hA5;
            exp_ram[a] = 8'(a * 37) ^ 8'hA5;
        end
        repeat (4) @(negedge clk_in);
        reset = 1'b0;
        @(negedge clk_in);

        base_errors = errors;
        check_state();
        check_value("write count", write_count, 0);
        finish_test("reset state", base_errors);

        base_errors = errors;
        repeat (chan_ops) send_byte(chan_list[$urandom_range(5, 0)]);
        check_state();
        finish_test("channel enables", base_errors);

        base_errors = errors;
        repeat (bright_ops) send_byte(bright_list[$urandom_range(7, 0)]);
        repeat (2) begin
            send_byte(read_brightness);
            send_byte(8'($urandom));
        end
        check_state();
        repeat (unknown_ops) begin
            do begin
                b = 8'($urandom);
            end while (is_opcode(b));
            send_byte(b);
        end
        check_state();
        finish_test("brightness and unknown opcodes", base_errors);

        base_errors = errors;
        repeat (pixel_ops) write_random_pixel();
        check_state();
        finish_test("pixel writes", base_errors);

        base_errors = errors;
        send_byte(fill_panel);
        repeat (pixel_bytes) send_byte(8'($urandom));
        wait_sweep();
        check_state();
        finish_test("fill panel", base_errors);

        base_errors = errors;
        repeat (pre_blank_ops) write_random_pixel();
        base_writes = write_count;
        send_byte(blank_panel);
        wait_sweep();
        check_state();
        check_value("blank writes", write_count - base_writes,
                    panel_rows * panel_cols * pixel_bytes);
        finish_test("blank panel", base_errors);

        errors += panel_control_inst.panel_control_assert_inst.assert_failures;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* design/byte_capture.sv */
// byte capture stage
// registers the host byte and flags it for one cycle
`timescale 1ns/1ns

module byte_capture import panel_cmd_pkg::*; (
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] data_rx,
    input  logic       data_ready_n,
    input  logic       ready_for_data,
    output cmd_byte_t  cap_byte
);

    logic accept;

    // strobe is active low, only taken while the writer can accept
    assign accept = !data_ready_n && ready_for_data;

    always_ff @(posedge clk_in) begin
        if (accept) begin
            cap_byte.data <= data_rx;
        end
        if (reset) begin
            cap_byte.valid <= 1'b0;
        end else begin
            cap_byte.valid <= accept;
        end
    end

endmodule

/* design/cmd_dispatch.sv */
// command dispatch stage
// decodes opcodes, keeps channel and brightness state, launches pixel jobs
`timescale 1ns/1ns

module cmd_dispatch import panel_geom_pkg::*, panel_cmd_pkg::*; (
    input  logic        clk_in,
    input  logic        reset,
    input  cmd_byte_t   cap_byte,
    input  logic        job_done,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable,
    output pixel_job_t  job
);

    typedef enum logic [1:0] {idle, wait_brightness, wait_job} state_t;

    state_t      state;
    opcode_t     opcode;
    brightness_t toggle_mask;

    assign opcode = opcode_t'(cap_byte.data);

    // brightness_one hits the heaviest bit
    always_comb begin
        toggle_mask = '0;
        case (opcode)
            brightness_one:   toggle_mask[brightness_levels-1] = 1'b1;
            brightness_two:   toggle_mask[brightness_levels-2] = 1'b1;
            brightness_three: toggle_mask[brightness_levels-3] = 1'b1;
            brightness_four:  toggle_mask[brightness_levels-4] = 1'b1;
            brightness_five:  toggle_mask[brightness_levels-5] = 1'b1;
            brightness_six:   toggle_mask[brightness_levels-6] = 1'b1;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= idle;
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
            job.start         <= 1'b0;
        end else begin
            job.start <= 1'b0;
            case (state)
                idle: begin
                    if (cap_byte.valid) begin
                        case (opcode)
                            red_enable:    rgb_enable[0] <= 1'b1;
                            red_disable:   rgb_enable[0] <= 1'b0;
                            green_enable:  rgb_enable[1] <= 1'b1;
                            green_disable: rgb_enable[1] <= 1'b0;
                            blue_enable:   rgb_enable[2] <= 1'b1;
                            blue_disable:  rgb_enable[2] <= 1'b0;
                            brightness_one, brightness_two, brightness_three,
                            brightness_four, brightness_five, brightness_six: begin
                                brightness_enable <= brightness_enable ^ toggle_mask;
                            end
                            brightness_zero: brightness_enable <= '0;
                            brightness_nine: brightness_enable <= '1;
                            read_brightness: state <= wait_brightness;
                            blank_panel: begin
                                job.start <= 1'b1;
                                job.kind  <= job_blank;
                                state     <= wait_job;
                            end
                            fill_panel: begin
                                job.start <= 1'b1;
                                job.kind  <= job_fill;
                                state     <= wait_job;
                            end
                            read_pixel: begin
                                job.start <= 1'b1;
                                job.kind  <= job_pixel;
                                state     <= wait_job;
                            end
                            // unknown opcodes fall through untouched
                            default: begin
                            end
                        endcase
                    end
                end
                wait_brightness: begin
                    if (cap_byte.valid) begin
                        brightness_enable <= cap_byte.data[brightness_levels-1:0];
                        state             <= idle;
                    end
                end
                // argument bytes belong to the writer here
                wait_job: begin
                    if (job_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* design/panel_cmd_pkg.sv */
// command package
// host opcodes, captured byte and pixel job hand-off between stages
package panel_cmd_pkg;

    typedef enum logic [7:0] {
        red_enable       = 8'h52,
        red_disable      = 8'h72,
        green_enable     = 8'h47,
        green_disable    = 8'h67,
        blue_enable      = 8'h42,
        blue_disable     = 8'h62,
        brightness_zero  = 8'h30,
        brightness_one   = 8'h31,
        brightness_two   = 8'h32,
        brightness_three = 8'h33,
        brightness_four  = 8'h34,
        brightness_five  = 8'h35,
        brightness_six   = 8'h36,
        brightness_nine  = 8'h39,
        read_brightness  = 8'h54,
        blank_panel      = 8'h5A,
        fill_panel       = 8'h46,
        read_pixel       = 8'h50
    } opcode_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } cmd_byte_t;

    typedef enum logic [1:0] {job_blank, job_fill, job_pixel} job_kind_t;

    typedef struct packed {
        logic      start;
        job_kind_t kind;
    } pixel_job_t;

endpackage

/* design/panel_control.sv */
// LED panel command front end
// byte capture, command dispatch and pixel writer in a three-stage pipeline
`timescale 1ns/1ns

module panel_control import panel_geom_pkg::*, panel_cmd_pkg::*; #(
    parameter int panel_rows = 4,
    parameter int panel_cols = 8
) (
    input  logic        clk_in,
    input  logic        reset,
    input  logic [7:0]  data_rx,
    input  logic        data_ready_n,
    output logic        ready_for_data,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable,
    output ram_write_t  ram_write
);

    cmd_byte_t  cap_byte;
    pixel_job_t job;
    logic       job_done;

    byte_capture byte_capture_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_rx        (data_rx),
        .data_ready_n   (data_ready_n),
        .ready_for_data (ready_for_data),
        .cap_byte       (cap_byte)
    );

    cmd_dispatch cmd_dispatch_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .cap_byte          (cap_byte),
        .job_done          (job_done),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .job               (job)
    );

    pixel_writer #(
        .panel_rows (panel_rows),
        .panel_cols (panel_cols)
    ) pixel_writer_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .cap_byte       (cap_byte),
        .job            (job),
        .ready_for_data (ready_for_data),
        .job_done       (job_done),
        .ram_write      (ram_write)
    );

endmodule

/* design/panel_geom_pkg.sv */
// panel geometry package
// frame-buffer addressing, RAM write port and brightness mask types
package panel_geom_pkg;

    // frame-buffer address widths
    localparam int row_w = 2;
    localparam int col_w = 3;

    // colour bytes per pixel, red first
    localparam int pixel_bytes = 3;

    localparam int brightness_levels = 6;

    typedef logic [row_w-1:0] row_addr_t;
    typedef logic [col_w-1:0] col_addr_t;
    typedef logic [1:0]       pixel_addr_t;

    typedef struct packed {
        row_addr_t   row;
        col_addr_t   col;
        pixel_addr_t pixel;
    } fb_addr_t;

    // msb carries the highest weight
    typedef logic [brightness_levels-1:0] brightness_t;

    typedef struct packed {
        logic       we;
        fb_addr_t   addr;
        logic [7:0] data;
    } ram_write_t;

endpackage

/* design/pixel_writer.sv */
// pixel writer stage
// collects job arguments, sweeps the frame buffer and registers RAM writes
`timescale 1ns/1ns

module pixel_writer import panel_geom_pkg::*, panel_cmd_pkg::*; #(
    parameter int panel_rows = 4,
    parameter int panel_cols = 8
) (
    input  logic       clk_in,
    input  logic       reset,
    input  cmd_byte_t  cap_byte,
    input  pixel_job_t job,
    output logic       ready_for_data,
    output logic       job_done,
    output ram_write_t ram_write
);

    typedef enum logic [1:0] {w_idle, w_fill_args, w_pixel_args, w_sweep} state_t;

    state_t     state;
    logic [2:0] arg_cnt;
    logic [7:0] fill_colour [pixel_bytes];
    logic       sweep_fill;
    fb_addr_t   sweep_addr;
    fb_addr_t   sweep_next;
    row_addr_t  pix_row;
    col_addr_t  pix_col;
    logic       pix_last;
    logic       col_last;
    logic       row_last;
    logic       sweep_last;

    assign pix_last   = sweep_addr.pixel == pixel_addr_t'(pixel_bytes - 1);
    assign col_last   = sweep_addr.col == col_addr_t'(panel_cols - 1);
    assign row_last   = sweep_addr.row == row_addr_t'(panel_rows - 1);
    assign sweep_last = pix_last && col_last && row_last;

    // pixel fastest, then column, then row
    always_comb begin
        sweep_next = sweep_addr;
        if (!pix_last) begin
            sweep_next.pixel = sweep_addr.pixel + 1'b1;
        end else begin
            sweep_next.pixel = '0;
            if (!col_last) begin
                sweep_next.col = sweep_addr.col + 1'b1;
            end else begin
                sweep_next.col = '0;
                sweep_next.row = sweep_addr.row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state          <= w_idle;
            ready_for_data <= 1'b1;
            job_done       <= 1'b0;
            ram_write.we   <= 1'b0;
        end else begin
            job_done     <= 1'b0;
            ram_write.we <= 1'b0;
            case (state)
                w_idle: begin
                    if (job.start) begin
                        arg_cnt    <= '0;
                        sweep_addr <= '0;
                        sweep_fill <= job.kind == job_fill;
                        case (job.kind)
                            job_blank: begin
                                state          <= w_sweep;
                                ready_for_data <= 1'b0;
                            end
                            job_fill:  state <= w_fill_args;
                            job_pixel: state <= w_pixel_args;
                            default:   state <= w_idle;
                        endcase
                    end
                end
                w_fill_args: begin
                    if (cap_byte.valid) begin
                        fill_colour[arg_cnt[1:0]] <= cap_byte.data;
                        arg_cnt <= arg_cnt + 1'b1;
                        if (arg_cnt == 3'(pixel_bytes - 1)) begin
                            state          <= w_sweep;
                            ready_for_data <= 1'b0;
                        end
                    end
                end
                // row, column, then one write per colour byte
                w_pixel_args: begin
                    if (cap_byte.valid) begin
                        arg_cnt <= arg_cnt + 1'b1;
                        case (arg_cnt)
                            3'd0: pix_row <= cap_byte.data[row_w-1:0];
                            3'd1: pix_col <= cap_byte.data[col_w-1:0];
                            default: begin
                                ram_write.we   <= 1'b1;
                                ram_write.addr <= {pix_row, pix_col, pixel_addr_t'(arg_cnt - 3'd2)};
                                ram_write.data <= cap_byte.data;
                                if (arg_cnt == 3'(pixel_bytes + 1)) begin
                                    job_done <= 1'b1;
                                    state    <= w_idle;
                                end
                            end
                        endcase
                    end
                end
                w_sweep: begin
                    ram_write.we   <= 1'b1;
                    ram_write.addr <= sweep_addr;
                    ram_write.data <= sweep_fill ? fill_colour[sweep_addr.pixel] : 8'h00;
                    sweep_addr     <= sweep_next;
                    if (sweep_last) begin
                        state          <= w_idle;
                        ready_for_data <= 1'b1;
                        job_done       <= 1'b1;
                    end
                end
                default: state <= w_idle;
            endcase
        end
    end

endmodule

/* vlog.f */
design/panel_geom_pkg.sv
design/panel_cmd_pkg.sv
design/byte_capture.sv
design/cmd_dispatch.sv
design/pixel_writer.sv
design/panel_control.sv
bench/panel_control_assert.sv
bench/panel_control_tb.sv
